// ==== verilog/wadj_cfg.svh ====
// width adjuster configuration: segment sizes, fifo depths and options
`ifndef WADJ_CFG_SVH
`define WADJ_CFG_SVH

// ------------------------------------------------------------------------
// segment and word shape
// ------------------------------------------------------------------------
`define WADJ_SEG_BYTES    8    // bytes per segment
`define WADJ_ENUM_SEG     4    // segments per egress word
`define WADJ_TID_W        3
`define WADJ_MD_W         1

// ------------------------------------------------------------------------
// buffering and flow control
// ------------------------------------------------------------------------
`define WADJ_IFIFO_DEPTH  64
`define WADJ_EFIFO_DEPTH  16
// free entries kept below full, covers the late ready and the in-flight word
`define WADJ_FC_MARGIN    4

// ------------------------------------------------------------------------
// output options
// ------------------------------------------------------------------------
`define WADJ_BYTE_ROTATE  1    // reverse byte order of the egress word

`endif

// ==== verilog/wadj_pkg.sv ====
// width adjuster types: ingress beat, egress word and segment info
`include "wadj_cfg.svh"

package wadj_pkg;

   // lane position inside the egress word
   typedef logic [$clog2(`WADJ_ENUM_SEG)-1:0] lane_idx_t;

   // ------------------------------------------------------------------------
   // one ingress beat, one segment wide
   // ------------------------------------------------------------------------
   typedef struct packed {
      logic [`WADJ_SEG_BYTES*8-1:0] tdata;
      logic [`WADJ_SEG_BYTES-1:0]   tkeep;   // one bit per byte
      logic [`WADJ_TID_W-1:0]       tid;
      logic [`WADJ_MD_W-1:0]        tuser_md;
      logic                         terr;
      logic                         tlast_segment;
      logic                         tlast;   // packet last
   } in_beat_t;

   // ------------------------------------------------------------------------
   // one egress word, lane 0 in the low bits
   // ------------------------------------------------------------------------
   typedef struct packed {
      logic [`WADJ_ENUM_SEG-1:0][`WADJ_SEG_BYTES*8-1:0] tdata;
      logic [`WADJ_ENUM_SEG-1:0][`WADJ_SEG_BYTES-1:0]   tkeep;
      logic [`WADJ_ENUM_SEG-1:0][`WADJ_TID_W-1:0]       tid;
      logic [`WADJ_ENUM_SEG-1:0]                        terr;
      logic [`WADJ_ENUM_SEG-1:0]                        tlast_segment;
      // from the latest beat of the word
      logic [`WADJ_MD_W-1:0]                            tuser_md;
      logic                                             tlast;
   } out_word_t;

   // per-word packet boundaries at egress
   typedef struct packed {
      logic sop;
      logic eop;
   } seg_info_t;

endpackage

// ==== verilog/beat_fifo.sv ====
// synchronous show-ahead fifo with occupancy count
`timescale 1ns/1ps

module beat_fifo #(
   parameter int WIDTH = 64,
   parameter int DEPTH = 16
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       push_i,
   input  logic                       pop_i,
   input  logic [WIDTH-1:0]           din_i,
   output logic [WIDTH-1:0]           dout_o,
   output logic                       empty_o,
   output logic [$clog2(DEPTH+1)-1:0] count_o
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH+1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign do_push = push_i && (count < DEPTH);   // drop when full
   assign do_pop  = pop_i && (count != '0);

   // ------------------------------------------------------------------------
   // pointers and count
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or push and pop together
         endcase
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= din_i;
      end
   end

   // head shown ahead of the pop
   assign dout_o  = mem[rd_ptr];
   assign empty_o = (count == '0);
   assign count_o = count;

endmodule

// ==== verilog/wadj_ctrl.sv ====
// width adjuster control: ingress ready, packet state, lane counter and pop
`timescale 1ns/1ps
`include "wadj_cfg.svh"

module wadj_ctrl (
   input  logic                                     clk,
   input  logic                                     rst,
   input  logic                                     tvld_i,
   input  logic                                     tlast_i,
   input  logic [$clog2(`WADJ_IFIFO_DEPTH+1)-1:0]   ififo_count_i,
   input  logic [$clog2(`WADJ_EFIFO_DEPTH+1)-1:0]   efifo_count_i,
   input  logic                                     ififo_empty_i,
   input  logic                                     head_tlast_i,
   output logic                                     trdy_o,
   output logic                                     sop_detect_o,
   output logic                                     ififo_push_o,
   output logic                                     ififo_pop_o,
   output wadj_pkg::lane_idx_t                      lane_idx_o
);

   localparam int IFIFO_WM  = `WADJ_IFIFO_DEPTH - `WADJ_FC_MARGIN;
   localparam int EFIFO_WM  = `WADJ_EFIFO_DEPTH - `WADJ_FC_MARGIN;
   localparam int LAST_LANE = `WADJ_ENUM_SEG - 1;

   logic                rdy_q;
   logic                pkt_open_q;   // ingress packet in progress
   wadj_pkg::lane_idx_t lane_q;
   logic                lane_close;

   // ------------------------------------------------------------------------
   // ingress side
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         rdy_q      <= 1'b0;
         pkt_open_q <= 1'b0;
      end else begin
         rdy_q <= (ififo_count_i < IFIFO_WM);   // one cycle late, margin covers it
         if (ififo_push_o) begin
            pkt_open_q <= !tlast_i;
         end
      end
   end

   assign trdy_o       = rdy_q;
   assign ififo_push_o = rdy_q && tvld_i;
   assign sop_detect_o = ififo_push_o && !pkt_open_q;   // first accepted beat

   // ------------------------------------------------------------------------
   // pop and lane counter
   // ------------------------------------------------------------------------
   // hold pops once the egress fifo reaches its watermark
   assign ififo_pop_o = !ififo_empty_i && (efifo_count_i < EFIFO_WM);

   // sop align: packet end also closes the word
   assign lane_close = head_tlast_i || (lane_q == LAST_LANE);

   always_ff @(posedge clk) begin
      if (rst) begin
         lane_q <= '0;
      end else if (ififo_pop_o) begin
         lane_q <= lane_close ? '0 : lane_q + 1'b1;
      end
   end

   assign lane_idx_o = lane_q;

endmodule

// ==== verilog/seg_gather.sv ====
// lane packing: places popped beats into the egress word and pushes it
`timescale 1ns/1ps
`include "wadj_cfg.svh"

module seg_gather (
   input  logic                clk,
   input  logic                rst,
   input  logic                pop_i,
   input  wadj_pkg::lane_idx_t lane_idx_i,
   input  wadj_pkg::in_beat_t  beat_i,
   output logic                push_o,
   output wadj_pkg::out_word_t word_o
);

   localparam int LAST_LANE = `WADJ_ENUM_SEG - 1;

   wadj_pkg::out_word_t word_q;
   logic                push_q;
   logic                close;

   // word done after this beat
   assign close = pop_i && (beat_i.tlast || (lane_idx_i == LAST_LANE));

   // ------------------------------------------------------------------------
   // word assembly
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (pop_i) begin
         // lanes above the current one hold nothing yet
         for (int i = 0; i < `WADJ_ENUM_SEG; i++) begin
            if (i > lane_idx_i) begin
               word_q.tkeep[i] <= '0;
            end
         end
         word_q.tdata[lane_idx_i]         <= beat_i.tdata;
         word_q.tkeep[lane_idx_i]         <= beat_i.tkeep;
         word_q.tid[lane_idx_i]           <= beat_i.tid;
         word_q.terr[lane_idx_i]          <= beat_i.terr;
         word_q.tlast_segment[lane_idx_i] <= beat_i.tlast_segment;
         word_q.tuser_md                  <= beat_i.tuser_md;   // latest beat wins
         word_q.tlast                     <= beat_i.tlast;
      end
   end

   // push trails the closing pop by one cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         push_q <= 1'b0;
      end else begin
         push_q <= close;
      end
   end

   assign push_o = push_q;
   assign word_o = word_q;   // egress fifo samples it on push

endmodule

// ==== verilog/egress_format.sv ====
// egress formatting: valid, sop/eop from packet state, optional byte reversal
`timescale 1ns/1ps
`include "wadj_cfg.svh"

module egress_format (
   input  logic                clk,
   input  logic                rst,
   input  wadj_pkg::out_word_t word_i,
   input  logic                empty_i,
   input  logic                pop_i,
   output logic                tvld_o,
   output wadj_pkg::out_word_t word_o,
   output wadj_pkg::seg_info_t seg_info_o
);

   localparam int NB = `WADJ_ENUM_SEG * `WADJ_SEG_BYTES;   // bytes per word

   logic                pkt_open_q;
   logic [NB-1:0][7:0]  bytes_in;
   logic [NB-1:0][7:0]  bytes_rev;

   // set on a non-last word, cleared by the last one
   always_ff @(posedge clk) begin
      if (rst) begin
         pkt_open_q <= 1'b0;
      end else if (pop_i && !empty_i) begin
         pkt_open_q <= !word_i.tlast;
      end
   end

   assign bytes_in = word_i.tdata;

   // top byte of the last lane lands in byte 0 of lane 0
   always_comb begin
      for (int i = 0; i < NB; i++) begin
         bytes_rev[i] = bytes_in[NB-1-i];
      end
      word_o = word_i;
      if (`WADJ_BYTE_ROTATE != 0) begin
         word_o.tdata = bytes_rev;
      end
   end

   assign tvld_o         = !empty_i;
   assign seg_info_o.sop = !empty_i && !pkt_open_q;
   assign seg_info_o.eop = word_i.tlast;

endmodule

// ==== verilog/wadj_top.sv ====
// width adjuster top: ingress fifo, lane packing, egress fifo and formatting
`timescale 1ns/1ps
`include "wadj_cfg.svh"

module wadj_top (
   input  logic                clk,
   input  logic                rst,
   input  logic                tvld_i,
   input  wadj_pkg::in_beat_t  beat_i,
   output logic                trdy_o,
   output logic                sop_detect_o,
   input  logic                efifo_pop_i,
   output logic                efifo_empty_o,
   output logic                tvld_o,
   output wadj_pkg::out_word_t word_o,
   output wadj_pkg::seg_info_t seg_info_o
);

   localparam int ICNT_W = $clog2(`WADJ_IFIFO_DEPTH+1);
   localparam int ECNT_W = $clog2(`WADJ_EFIFO_DEPTH+1);

   logic                ififo_push;
   logic                ififo_pop;
   logic                ififo_empty;
   logic [ICNT_W-1:0]   ififo_count;
   wadj_pkg::in_beat_t  ihead;        // ingress fifo head
   wadj_pkg::lane_idx_t lane_idx;
   logic                efifo_push;
   logic                efifo_empty;
   logic [ECNT_W-1:0]   efifo_count;
   wadj_pkg::out_word_t gather_word;
   wadj_pkg::out_word_t ehead;        // egress fifo head

   // ------------------------------------------------------------------------
   // ingress
   // ------------------------------------------------------------------------
   beat_fifo #(.WIDTH($bits(wadj_pkg::in_beat_t)), .DEPTH(`WADJ_IFIFO_DEPTH)) ififo (
      .clk(clk), .rst(rst), .push_i(ififo_push), .pop_i(ififo_pop),
      .din_i(beat_i), .dout_o(ihead), .empty_o(ififo_empty), .count_o(ififo_count)
   );

   wadj_ctrl ctrl (
      .clk(clk), .rst(rst), .tvld_i(tvld_i), .tlast_i(beat_i.tlast),
      .ififo_count_i(ififo_count), .efifo_count_i(efifo_count),
      .ififo_empty_i(ififo_empty), .head_tlast_i(ihead.tlast),
      .trdy_o(trdy_o), .sop_detect_o(sop_detect_o), .ififo_push_o(ififo_push),
      .ififo_pop_o(ififo_pop), .lane_idx_o(lane_idx)
   );

   seg_gather gather (
      .clk(clk), .rst(rst), .pop_i(ififo_pop), .lane_idx_i(lane_idx),
      .beat_i(ihead), .push_o(efifo_push), .word_o(gather_word)
   );

   // ------------------------------------------------------------------------
   // egress
   // ------------------------------------------------------------------------
   beat_fifo #(.WIDTH($bits(wadj_pkg::out_word_t)), .DEPTH(`WADJ_EFIFO_DEPTH)) efifo (
      .clk(clk), .rst(rst), .push_i(efifo_push), .pop_i(efifo_pop_i),
      .din_i(gather_word), .dout_o(ehead), .empty_o(efifo_empty), .count_o(efifo_count)
   );

   egress_format fmt (
      .clk(clk), .rst(rst), .word_i(ehead), .empty_i(efifo_empty), .pop_i(efifo_pop_i),
      .tvld_o(tvld_o), .word_o(word_o), .seg_info_o(seg_info_o)
   );

   assign efifo_empty_o = efifo_empty;

endmodule

// ==== verification/tb_wadj.sv ====
// width adjuster testbench checking random packets against a packing model
`timescale 1ns/1ps
`include "wadj_cfg.svh"

module tb_wadj;

   localparam int SEG         = `WADJ_ENUM_SEG;
   localparam int NB          = `WADJ_ENUM_SEG * `WADJ_SEG_BYTES;
   localparam int WORD_W      = NB * 8;
   localparam int NUM_PKTS    = 48;
   localparam int STALL_START = 80;    // cycle count where the sink stops
   localparam int STALL_LEN   = 300;

   logic                clk;
   logic                rst;
   logic                tvld_i;
   wadj_pkg::in_beat_t  beat_i;
   logic                trdy_o;
   logic                sop_detect_o;
   logic                efifo_pop_i;
   logic                efifo_empty_o;
   logic                tvld_o;
   wadj_pkg::out_word_t word_o;
   wadj_pkg::seg_info_t seg_info_o;

   wadj_pkg::in_beat_t  pkt_beats [16];   // packet currently being sent
   wadj_pkg::out_word_t exp_word_q [$];
   logic                exp_sop_q [$];
   int                  len_a [NUM_PKTS];
   logic [31:0]         stim_seed;
   logic [31:0]         pop_seed;
   int                  cycle_cnt;
   int                  cycle_limit;
   int                  val_errs;
   int                  other_errs;
   int                  words_seen;
   int                  sop_pulses;
   logic                first_drv;
   logic                accept_s;        // beat taken at the coming edge
   logic                vld_s;
   logic                trdy_low_seen;

   wadj_top DUT (
      .clk(clk), .rst(rst), .tvld_i(tvld_i), .beat_i(beat_i), .trdy_o(trdy_o),
      .sop_detect_o(sop_detect_o), .efifo_pop_i(efifo_pop_i),
      .efifo_empty_o(efifo_empty_o), .tvld_o(tvld_o), .word_o(word_o),
      .seg_info_o(seg_info_o)
   );

   always #5 clk = ~clk;

   // ------------------------------------------------------------------------
   // random source and reference model
   // ------------------------------------------------------------------------
   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic next_rand(output logic [15:0] v);
      stim_seed = lcg_step(stim_seed);
      v = stim_seed[31:16];   // upper bits since the low ones cycle fast
   endtask

   task automatic make_beat(input logic last, output wadj_pkg::in_beat_t b);
      logic [15:0] r;
      b = '0;
      for (int j = 0; j < 4; j++) begin
         next_rand(r);
         b.tdata[j*16 +: 16] = r;
      end
      next_rand(r);
      b.tkeep = '1;
      if (last) begin
         b.tkeep = b.tkeep >> r[2:0];   // 1 to 8 low bytes
      end
      b.tid           = r[5:3];
      b.tuser_md      = r[6];
      b.terr          = (r[10:7] == 4'd0);
      b.tlast_segment = r[11];
      b.tlast         = last;
   endtask

   function automatic logic [WORD_W-1:0] reverse_bytes(input logic [WORD_W-1:0] d);
      logic [WORD_W-1:0] r;
      for (int i = 0; i < NB; i++) begin
         r[i*8 +: 8] = d[(NB-1-i)*8 +: 8];
      end
      return r;
   endfunction

   // beats first..first+n-1 fill lanes 0..n-1 and the rest stays empty
   function automatic wadj_pkg::out_word_t ref_word(input int first, input int n);
      wadj_pkg::out_word_t w;
      w = '0;
      for (int k = 0; k < n; k++) begin
         w.tdata[k]         = pkt_beats[first+k].tdata;
         w.tkeep[k]         = pkt_beats[first+k].tkeep;
         w.tid[k]           = pkt_beats[first+k].tid;
         w.terr[k]          = pkt_beats[first+k].terr;
         w.tlast_segment[k] = pkt_beats[first+k].tlast_segment;
      end
      w.tuser_md = pkt_beats[first+n-1].tuser_md;
      w.tlast    = pkt_beats[first+n-1].tlast;
      if (`WADJ_BYTE_ROTATE != 0) begin
         w.tdata = reverse_bytes(w.tdata);
      end
      return w;
   endfunction

   // ------------------------------------------------------------------------
   // reporting
   // ------------------------------------------------------------------------
   task automatic report_mismatch(input string test, input logic [63:0] exp,
                                  input logic [63:0] act);
      val_errs++;
      $display("Fail %s at %0t: expected %h, actual %h", test, $time, exp, act);
   endtask

   task automatic report_error(input string msg);
      other_errs++;
      $display("Error at %0t: %s", $time, msg);
   endtask

   task automatic print_counts();
      $display("words checked %0d, value mismatches %0d, other failures %0d",
               words_seen, val_errs, other_errs);
   endtask

   task automatic check_word();
      wadj_pkg::out_word_t exp;
      logic                exp_sop;
      int                  src;
      exp     = exp_word_q.pop_front();
      exp_sop = exp_sop_q.pop_front();
      for (int k = 0; k < SEG; k++) begin
         src = (`WADJ_BYTE_ROTATE != 0) ? SEG - 1 - k : k;   // lane whose bytes land here
         if (exp.tkeep[src] != '0 && word_o.tdata[k] !== exp.tdata[k]) begin
            report_mismatch($sformatf("packing word %0d tdata lane %0d", words_seen, k),
                            exp.tdata[k], word_o.tdata[k]);
         end
         if (word_o.tkeep[k] !== exp.tkeep[k]) begin
            report_mismatch($sformatf("%s word %0d tkeep lane %0d",
                            (exp.tkeep[k] == '0) ? "sop_alignment" : "packing",
                            words_seen, k), exp.tkeep[k], word_o.tkeep[k]);
         end
         if (exp.tkeep[k] != '0) begin
            if (word_o.tid[k] !== exp.tid[k]) begin
               report_mismatch($sformatf("packing word %0d tid lane %0d", words_seen, k),
                               exp.tid[k], word_o.tid[k]);
            end
            if (word_o.terr[k] !== exp.terr[k]) begin
               report_mismatch($sformatf("packing word %0d terr lane %0d", words_seen, k),
                               exp.terr[k], word_o.terr[k]);
            end
            if (word_o.tlast_segment[k] !== exp.tlast_segment[k]) begin
               report_mismatch($sformatf("packing word %0d tlast_segment lane %0d",
                               words_seen, k), exp.tlast_segment[k], word_o.tlast_segment[k]);
            end
         end
      end
      if (word_o.tuser_md !== exp.tuser_md) begin
         report_mismatch($sformatf("packing word %0d tuser_md", words_seen),
                         exp.tuser_md, word_o.tuser_md);
      end
      if (word_o.tlast !== exp.tlast) begin
         report_mismatch($sformatf("sop_alignment word %0d tlast", words_seen),
                         exp.tlast, word_o.tlast);
      end
      if (seg_info_o.sop !== exp_sop) begin
         report_mismatch($sformatf("segment_info word %0d sop", words_seen),
                         exp_sop, seg_info_o.sop);
      end
      if (seg_info_o.eop !== exp.tlast) begin
         report_mismatch($sformatf("segment_info word %0d eop", words_seen),
                         exp.tlast, seg_info_o.eop);
      end
      words_seen++;
   endtask

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------
   initial begin : stimulus
      logic [15:0]        r;
      int                 total;
      int                 gap;
      wadj_pkg::in_beat_t b;
      clk           = 1'b0;
      rst           = 1'b1;
      tvld_i        = 1'b0;
      beat_i        = '0;
      efifo_pop_i   = 1'b0;
      first_drv     = 1'b0;
      accept_s      = 1'b0;
      vld_s         = 1'b0;
      trdy_low_seen = 1'b0;
      stim_seed     = 32'd60;
      pop_seed      = 32'd60;
      cycle_cnt     = 0;
      val_errs      = 0;
      other_errs    = 0;
      words_seen    = 0;
      sop_pulses    = 0;
      total         = 0;
      for (int p = 0; p < NUM_PKTS; p++) begin
         next_rand(r);
         len_a[p] = r % 11 + 1;
         total += len_a[p];
      end
      cycle_limit = 10 * total + 500;

      repeat (10) @(posedge clk);
      rst <= 1'b0;

      for (int p = 0; p < NUM_PKTS; p++) begin
         for (int i = 0; i < len_a[p]; i++) begin
            make_beat(i == len_a[p] - 1, b);
            pkt_beats[i] = b;
            next_rand(r);
            gap = (r[3:0] < 4'd5) ? r[5:4] + 1 : 0;   // idle cycles before the beat
            if (gap > 0) begin
               tvld_i <= 1'b0;
               repeat (gap) @(posedge clk);
            end
            tvld_i    <= 1'b1;
            beat_i    <= b;
            first_drv <= (i == 0);
            @(posedge clk);
            while (!accept_s) @(posedge clk);
            // a full group or the packet end closes one egress word
            if ((i % SEG) == SEG - 1 || i == len_a[p] - 1) begin
               exp_word_q.push_back(ref_word(i - i % SEG, i % SEG + 1));
               exp_sop_q.push_back(i < SEG);
            end
         end
      end
      tvld_i    <= 1'b0;
      first_drv <= 1'b0;

      while (exp_word_q.size() != 0) @(posedge clk);
      repeat (10) @(posedge clk);
      if (efifo_empty_o !== 1'b1) begin
         report_mismatch("drained efifo_empty_o", 1'b1, efifo_empty_o);
      end
      if (sop_pulses != NUM_PKTS) begin
         report_mismatch("sop_detect pulse count", NUM_PKTS, sop_pulses);
      end
      if (!trdy_low_seen) begin
         report_error("ready never went low while the sink was stalled");
      end
      print_counts();
      if (val_errs == 0 && other_errs == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // sink pops at most every other cycle so tvld_o is known to hold
   always @(posedge clk) begin
      if (rst) begin
         efifo_pop_i <= 1'b0;
      end else begin
         pop_seed = lcg_step(pop_seed);
         if (cycle_cnt >= STALL_START && cycle_cnt < STALL_START + STALL_LEN) begin
            efifo_pop_i <= 1'b0;
         end else begin
            efifo_pop_i <= vld_s && !efifo_pop_i && (pop_seed[17:16] != 2'b00);
         end
      end
   end

   // ------------------------------------------------------------------------
   // sampling and comparison at mid cycle
   // ------------------------------------------------------------------------
   always @(negedge clk) begin
      accept_s = tvld_i && trdy_o;
      vld_s    = tvld_o;
      if (!rst) begin
         if (sop_detect_o === 1'b1) begin
            sop_pulses++;
         end
         if (sop_detect_o !== (tvld_i && trdy_o && first_drv)) begin
            report_mismatch("sop_detect pulse", tvld_i && trdy_o && first_drv, sop_detect_o);
         end
         if (efifo_empty_o !== !tvld_o) begin
            report_mismatch("egress empty flag", !tvld_o, efifo_empty_o);
         end
         if (cycle_cnt >= STALL_START && cycle_cnt < STALL_START + STALL_LEN && !trdy_o) begin
            trdy_low_seen = 1'b1;
         end
         if (efifo_pop_i) begin
            if (!tvld_o) begin
               report_error("sink popped while the egress fifo was empty");
            end else if (exp_word_q.size() == 0) begin
               report_error("egress word popped with no expected word left");
            end else begin
               check_word();
            end
         end
      end
   end

   // reset cycles plus the first cycle after
   initial begin : reset_check
      @(posedge clk);
      repeat (10) begin
         @(negedge clk);
         if (trdy_o !== 1'b0) begin
            report_mismatch("reset trdy_o", 1'b0, trdy_o);
         end
         if (tvld_o !== 1'b0) begin
            report_mismatch("reset tvld_o", 1'b0, tvld_o);
         end
         if (efifo_empty_o !== 1'b1) begin
            report_mismatch("reset efifo_empty_o", 1'b1, efifo_empty_o);
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         report_error($sformatf("run hit the cycle limit of %0d with %0d words still expected",
                      cycle_limit, exp_word_q.size()));
         print_counts();
         $display("SIMULATION FAILED");
         $finish;
      end
   end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/wadj_pkg.sv
verilog/beat_fifo.sv
verilog/wadj_ctrl.sv
verilog/seg_gather.sv
verilog/egress_format.sv
verilog/wadj_top.sv
verification/tb_wadj.sv

// ==== Bender.yml ====
package:
  name: wadj

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/wadj_pkg.sv
      - verilog/beat_fifo.sv
      - verilog/wadj_ctrl.sv
      - verilog/seg_gather.sv
      - verilog/egress_format.sv
      - verilog/wadj_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_wadj.sv
